//--- tb.f
+incdir+rtl
+incdir+dv
rtl/vmul_pkg.sv
rtl/vmul_operand_decode.sv
rtl/vmul_partial_array.sv
rtl/vmul_result_merge.sv
rtl/vmul_unit.sv
dv/vmul_tb.sv

//--- run.sh
#!/usr/bin/env bash
# builds the vmul testbench with Verilator and runs it
# the exit status of the simulation is the test result
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module vmul_tb -Mdir obj_dir -o vmul_sim
./obj_dir/vmul_sim

//--- dv/vmul_ref.svh
// reference model for the vector multiply unit, included inside the testbench module
// works on one element at a time, SEW of 8, 16 or 32
// needs vmul_pkg imported by the including module
`ifndef VMUL_REF_SVH
`define VMUL_REF_SVH

function automatic logic [63:0] elem_mask(input int sew);
  return (64'd1 << sew) - 64'd1;
endfunction

// SEW-bit value widened to 64 bits
function automatic logic [63:0] extend(input logic [31:0] v, input int sew, input logic sgn);
  logic [63:0] r;
  r = {32'd0, v} & elem_mask(sew);
  if (sgn && r[sew-1]) begin
    r = r | ~elem_mask(sew);
  end
  return r;
endfunction

// fixed-point shift by SEW-1 with the vxrm increment
function automatic logic [31:0] fixed_round(input logic [63:0] p, input int sew,
                                            input logic [1:0] vxrm);
  logic        lsb;
  logic        half;
  logic        low;
  logic        inc;
  logic [63:0] q;
  lsb  = p[sew-1];                          // kept lsb
  half = p[sew-2];                          // first discarded bit
  low  = (p & elem_mask(sew - 2)) != 64'd0; // the rest of the discarded bits
  case (vxrm)
    2'd0:    inc = half;
    2'd1:    inc = half & (low | lsb);
    2'd2:    inc = 1'b0;
    default: inc = ~lsb & (half | low);
  endcase
  q = (p >> (sew - 1)) + {63'd0, inc};
  return 32'(q & elem_mask(sew));
endfunction

// {saturated, element result}
function automatic logic [32:0] ref_elem(input logic [5:0] f6, input logic [2:0] f3,
                                         input logic [1:0] vxrm, input int sew,
                                         input logic [31:0] a, input logic [31:0] b);
  logic        sa;
  logic        sb;
  logic        high;
  logic        vsmul;
  logic [63:0] p;
  logic [63:0] mn;
  vsmul = (f3 == OPIVV) || (f3 == OPIVX);
  sa    = 1'b1;
  sb    = 1'b1;
  high  = 1'b1;
  if (!vsmul) begin
    case (f6)
      VMULH:   high = 1'b1;
      VMULHU: begin
        sa = 1'b0;
        sb = 1'b0;
      end
      VMULHSU: sb = 1'b0;
      default: high = 1'b0; // vmul and unknown codes
    endcase
  end
  p  = extend(a, sew, sa) * extend(b, sew, sb);
  mn = 64'd1 << (sew - 1);
  if (vsmul && (({32'd0, a} & elem_mask(sew)) == mn) && (({32'd0, b} & elem_mask(sew)) == mn))
    return {1'b1, 32'(mn - 64'd1)};
  if (vsmul)
    return {1'b0, fixed_round(p, sew, vxrm)};
  if (high)
    return {1'b0, 32'((p >> sew) & elem_mask(sew))};
  return {1'b0, 32'(p & elem_mask(sew))};
endfunction

`endif

//--- dv/vmul_tb.sv
// testbench for vmul_unit, table driven, inputs change on the falling edge
// outputs are checked one cycle after each uop, the fixed latency of the unit
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_tb
  import vmul_pkg::*;
();

  typedef struct packed {
    funct3_e    funct3;
    logic [5:0] f6;     // raw, so unknown codes can be sent
    eew_e       eew;
    vxrm_e      vxrm;
    logic       corner; // corner data, else random
    logic       gap;    // idle cycle after this row
  } row_t;

  localparam int NROWS       = 24;
  localparam int WATCHDOG_NS = (NROWS * 2 + 20) * 40; // a row takes at most two cycles

  localparam row_t TABLE [NROWS] = '{
    '{OPMVV, VMUL,    EEW8,  RNU, 1'b0, 1'b0},
    '{OPMVV, VMUL,    EEW16, RNU, 1'b0, 1'b0},
    '{OPMVV, VMUL,    EEW32, RNU, 1'b0, 1'b1},
    '{OPMVV, VMULH,   EEW8,  RNU, 1'b1, 1'b0},
    '{OPMVV, VMULH,   EEW32, RNU, 1'b0, 1'b0},
    '{OPMVV, VMULHU,  EEW16, RNU, 1'b1, 1'b0},
    '{OPMVV, VMULHU,  EEW32, RNU, 1'b0, 1'b1},
    '{OPMVV, VMULHSU, EEW8,  RNU, 1'b0, 1'b0},
    '{OPMVV, VMULHSU, EEW16, RNU, 1'b1, 1'b0},
    '{OPMVV, 6'h00,   EEW32, RNU, 1'b0, 1'b1},
    '{OPMVX, VMUL,    EEW16, RNU, 1'b0, 1'b0},
    '{OPMVX, VMULH,   EEW8,  RNU, 1'b1, 1'b0},
    '{OPMVX, VMULHSU, EEW32, RNU, 1'b0, 1'b1},
    '{OPIVV, VSMUL,   EEW8,  RNU, 1'b0, 1'b0},
    '{OPIVV, VSMUL,   EEW16, RNE, 1'b0, 1'b0},
    '{OPIVV, VSMUL,   EEW32, RDN, 1'b0, 1'b0},
    '{OPIVV, VSMUL,   EEW8,  ROD, 1'b0, 1'b1},
    '{OPIVV, VSMUL,   EEW8,  RNE, 1'b1, 1'b0},
    '{OPIVV, VSMUL,   EEW16, ROD, 1'b1, 1'b0},
    '{OPIVV, VSMUL,   EEW32, RNU, 1'b1, 1'b0},
    '{OPIVX, VSMUL,   EEW16, RNU, 1'b1, 1'b1},
    '{OPIVX, 6'h00,   EEW32, ROD, 1'b0, 1'b0},
    '{OPIVV, VSMUL,   EEW16, RDN, 1'b0, 1'b0},
    '{OPIVV, VSMUL,   EEW32, RNE, 1'b0, 1'b0}
  };

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  mul_uop_t    in_uop;
  logic        out_valid;
  mul_result_t out_result;

  logic [31:0]            rng;
  logic [`VMUL_ROB_W-1:0] pend_q [$];          // rob entries in flight
  logic [`VMUL_VLEN-1:0]  exp_data [1 << `VMUL_ROB_W];
  logic [`VMUL_VLENB-1:0] exp_sat [1 << `VMUL_ROB_W];

  `include "vmul_ref.svh"

  vmul_unit u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_uop     (in_uop),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int sew_of(input eew_e w);
    case (w)
      EEW16:   return 16;
      EEW32:   return 32;
      default: return 8;
    endcase
  endfunction

  // most negative, all ones, zero, most negative
  function automatic logic [31:0] corner_elem(input int sew, input int idx);
    case (idx % 4)
      1:       return 32'(elem_mask(sew));
      2:       return 32'd0;
      default: return 32'(64'd1 << (sew - 1));
    endcase
  endfunction

  task automatic make_uop(input row_t r, input int idx, output mul_uop_t u);
    int sew;
    sew           = sew_of(r.eew);
    u             = '0;
    u.rob_entry   = idx[`VMUL_ROB_W-1:0];
    u.funct6      = funct6_e'(r.f6);
    u.funct3      = r.funct3;
    u.vxrm        = r.vxrm;
    u.vs2_eew     = r.eew;
    if (r.corner) begin
      for (int e = 0; e < `VMUL_VLEN / sew; e++) begin
        u.vs2_data = u.vs2_data | (`VMUL_VLEN'(corner_elem(sew, e)) << (e * sew));
        u.vs1_data = u.vs1_data | (`VMUL_VLEN'(corner_elem(sew, e + e / 4)) << (e * sew));
      end
      u.rs1_data = corner_elem(sew, 0);
    end else begin
      for (int w = 0; w < `VMUL_VLEN / 32; w++) begin
        rng                     = xorshift(rng);
        u.vs2_data[32*w +: 32]  = rng;
        rng                     = xorshift(rng);
        u.vs1_data[32*w +: 32]  = rng;
      end
      rng        = xorshift(rng);
      u.rs1_data = rng;
    end
  endtask

  function automatic void expect_result(input mul_uop_t u,
                                        output logic [`VMUL_VLEN-1:0] data,
                                        output logic [`VMUL_VLENB-1:0] sat);
    int          sew;
    int          nb;
    logic        is_vx;
    logic [31:0] b;
    logic [32:0] r;
    sew   = sew_of(u.vs2_eew);
    nb    = sew / 8;
    data  = '0;
    sat   = '0;
    is_vx = (u.funct3 == OPIVX) || (u.funct3 == OPMVX);
    for (int e = 0; e < `VMUL_VLEN / sew; e++) begin
      b    = is_vx ? u.rs1_data : 32'(u.vs1_data >> (e * sew));
      r    = ref_elem(u.funct6, u.funct3, u.vxrm, sew, 32'(u.vs2_data >> (e * sew)), b);
      data = data | (`VMUL_VLEN'(r[31:0]) << (e * sew));
      sat[e*nb + nb - 1] = r[32]; // top byte of the element
    end
  endfunction

  //////////////////////////////
  // checking
  //////////////////////////////
  task automatic check_value(input string name, input logic [`VMUL_VLEN-1:0] got,
                             input logic [`VMUL_VLEN-1:0] exp);
    if (got !== exp) begin
      $display("Error: %s got %h expected %h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic check_outputs();
    logic [`VMUL_ROB_W-1:0] rob;
    check_value("out_valid", `VMUL_VLEN'(out_valid), `VMUL_VLEN'(pend_q.size() != 0));
    if (pend_q.size() != 0) begin
      rob = pend_q.pop_front();
      check_value("out_result.rob_entry", `VMUL_VLEN'(out_result.rob_entry), `VMUL_VLEN'(rob));
      check_value("out_result.w_data", out_result.w_data, exp_data[rob]);
      check_value("out_result.vsaturate", `VMUL_VLEN'(out_result.vsaturate),
                  `VMUL_VLEN'(exp_sat[rob]));
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish in the expected time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    mul_uop_t               uop;
    logic [`VMUL_VLEN-1:0]  d;
    logic [`VMUL_VLENB-1:0] s;
    rng      = 32'h25803751;
    rst_n    = 1'b0;
    in_valid = 1'b0;
    in_uop   = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) begin // idle after reset
      @(negedge clk);
      check_outputs();
    end
    for (int i = 0; i < NROWS; i++) begin
      @(negedge clk);
      check_outputs();
      make_uop(TABLE[i], i, uop);
      in_uop   = uop;
      in_valid = 1'b1;
      expect_result(uop, d, s);
      exp_data[uop.rob_entry] = d;
      exp_sat[uop.rob_entry]  = s;
      pend_q.push_back(uop.rob_entry);
      if (TABLE[i].gap) begin
        @(negedge clk);
        check_outputs();
        in_valid = 1'b0;
        in_uop   = '0;
      end
    end
    @(negedge clk);
    check_outputs();
    in_valid = 1'b0;
    @(negedge clk);
    check_outputs();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

//--- rtl/vmul_unit.sv
// vector integer multiply unit, one uop per cycle, result one cycle later
// no back-pressure; the consumer takes every out_valid cycle
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_unit
  import vmul_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        in_valid,
  input  mul_uop_t    in_uop,
  output logic        out_valid,
  output mul_result_t out_result
);

  logic [`VMUL_VLEN-1:0]      src2;
  logic [`VMUL_VLEN-1:0]      src1;
  logic [`VMUL_VLENB-1:0]     src2_sign;
  logic [`VMUL_VLENB-1:0]     src1_sign;
  mul_ctrl_t                  ctrl;
  logic                       valid_q;
  logic [`VMUL_PROD_N*16-1:0] prod;
  mul_ctrl_t                  ctrl_q;

  vmul_operand_decode u_decode (
    .in_valid  (in_valid),
    .in_uop    (in_uop),
    .src2      (src2),
    .src1      (src1),
    .src2_sign (src2_sign),
    .src1_sign (src1_sign),
    .ctrl      (ctrl)
  );

  vmul_partial_array u_array (
    .clk       (clk),
    .rst_n     (rst_n),
    .valid     (in_valid),    // registered as valid_q
    .src2      (src2),
    .src1      (src1),
    .src2_sign (src2_sign),
    .src1_sign (src1_sign),
    .ctrl      (ctrl),
    .valid_q   (valid_q),
    .prod      (prod),
    .ctrl_q    (ctrl_q)
  );

  vmul_result_merge u_merge (
    .valid_q    (valid_q),
    .prod       (prod),
    .ctrl_q     (ctrl_q),
    .out_valid  (out_valid),
    .out_result (out_result)
  );

endmodule

//--- rtl/vmul_result_merge.sv
// combines registered 8x8 products into per-element results
// vsmul keeps (a*b) >> (SEW-1) with vxrm rounding; only min*min saturates
// saturate mask bits sit on each element's most significant byte
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_result_merge
  import vmul_pkg::*;
(
  input  logic                       valid_q,
  input  logic [`VMUL_PROD_N*16-1:0] prod,
  input  mul_ctrl_t                  ctrl_q,
  output logic                       out_valid,
  output mul_result_t                out_result
);

  localparam int PN = `VMUL_PROD_N;

  logic [`VMUL_VLEN-1:0]  res8;
  logic [`VMUL_VLEN-1:0]  res16;
  logic [`VMUL_VLEN-1:0]  res32;
  logic [`VMUL_VLENB-1:0] sat8;
  logic [`VMUL_VLENB-1:0] sat16;
  logic [`VMUL_VLENB-1:0] sat32;

  // full 2*SEW product of element e, nb bytes wide; only low 2*SEW bits are meaningful
  function automatic logic [63:0] elem_full(
    input logic [PN*16-1:0] p,
    input int               e,
    input int               nb,
    input logic             s2,
    input logic             s1
  );
    int          z;
    int          b0;
    logic [15:0] pp;
    logic        ext;
    logic [63:0] acc;
    z   = (e * nb) / 4;    // lane
    b0  = (e * nb) % 4;    // first byte inside the lane
    acc = '0;
    for (int by = 0; by < nb; by++) begin
      for (int bx = 0; bx < nb; bx++) begin
        pp  = p[(z*16 + (b0 + by)*4 + b0 + bx)*16 +: 16];
        // a partial is signed if it used the top byte of a signed operand
        ext = pp[15] & (((bx == nb - 1) && s2) || ((by == nb - 1) && s1));
        acc = acc + ({{48{ext}}, pp} << (8 * (bx + by)));
      end
    end
    return acc;
  endfunction

  // {saturate, result}; result is right aligned in 32 bits
  function automatic logic [32:0] elem_out(
    input logic [63:0] full,
    input int          nb,
    input mul_ctrl_t   c
  );
    int          sew;
    logic [63:0] mask;
    logic        lsb;
    logic        dbit;
    logic        rest;
    logic        incr;
    logic        sat;
    logic [31:0] res;
    sew  = 8 * nb;
    mask = (64'd1 << sew) - 64'd1;
    lsb  = full[sew-1];                                 // kept lsb after >> (SEW-1)
    dbit = full[sew-2];                                 // first dropped bit
    rest = |(full & ((64'd1 << (sew - 2)) - 64'd1));    // remaining dropped bits
    case (c.vxrm)
      RNU:     incr = dbit;
      RNE:     incr = dbit & (rest | lsb);
      RDN:     incr = 1'b0;
      default: incr = ~lsb & (dbit | rest); // rod
    endcase
    sat = c.is_vsmul && (full[2*sew-1 -: 2] == 2'b01); // only min x min lands here
    if (sat) begin
      res = 32'(mask >> 1); // largest positive
    end else if (c.is_vsmul) begin
      res = 32'(((full >> (sew - 1)) + 64'(incr)) & mask);
    end else if (c.keep_low) begin
      res = 32'(full & mask);
    end else begin
      res = 32'((full >> sew) & mask);
    end
    return {sat, res};
  endfunction

  //////////////////////////////
  // per-width results
  //////////////////////////////
  always_comb begin
    logic [32:0] o;
    for (int e = 0; e < `VMUL_VLENB; e++) begin
      o = elem_out(elem_full(prod, e, 1, ctrl_q.src2_signed, ctrl_q.src1_signed), 1, ctrl_q);
      res8[8*e +: 8] = o[7:0];
      sat8[e]        = o[32];
    end
  end

  always_comb begin
    logic [32:0] o;
    sat16 = '0;
    for (int e = 0; e < `VMUL_VLENB/2; e++) begin
      o = elem_out(elem_full(prod, e, 2, ctrl_q.src2_signed, ctrl_q.src1_signed), 2, ctrl_q);
      res16[16*e +: 16] = o[15:0];
      sat16[2*e + 1]    = o[32]; // top byte of the element
    end
  end

  always_comb begin
    logic [32:0] o;
    sat32 = '0;
    for (int e = 0; e < `VMUL_VLENB/4; e++) begin
      o = elem_out(elem_full(prod, e, 4, ctrl_q.src2_signed, ctrl_q.src1_signed), 4, ctrl_q);
      res32[32*e +: 32] = o[31:0];
      sat32[4*e + 3]    = o[32];
    end
  end

  //////////////////////////////
  // output pack
  //////////////////////////////
  assign out_valid = valid_q;

  always_comb begin
    out_result.rob_entry = ctrl_q.rob_entry;
    case (ctrl_q.eew)
      EEW32: begin
        out_result.w_data    = res32;
        out_result.vsaturate = sat32;
      end
      EEW16: begin
        out_result.w_data    = res16;
        out_result.vsaturate = sat16;
      end
      default: begin // eew8, same fallback as decode
        out_result.w_data    = res8;
        out_result.vsaturate = sat8;
      end
    endcase
  end

endmodule

//--- rtl/vmul_partial_array.sv
// tiled 8x8 multiplier array with the unit's only register stage
// product index is lane*16 + src1_byte*4 + src2_byte, bytes counted inside the lane
// every byte pair in a 32-bit lane is multiplied whatever the element width
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_partial_array
  import vmul_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          valid,
  input  logic [`VMUL_VLEN-1:0]         src2,
  input  logic [`VMUL_VLEN-1:0]         src1,
  input  logic [`VMUL_VLENB-1:0]        src2_sign,
  input  logic [`VMUL_VLENB-1:0]        src1_sign,
  input  mul_ctrl_t                     ctrl,
  output logic                          valid_q,
  output logic [`VMUL_PROD_N*16-1:0]    prod,
  output mul_ctrl_t                     ctrl_q
);

  localparam int LANES = `VMUL_VLENB / 4;

  logic [`VMUL_PROD_N*16-1:0] prod_d;

  // one 8x8 multiply, each byte signed when its flag is set
  function automatic logic [15:0] mul8(
    input logic [7:0] a,
    input logic       sa,
    input logic [7:0] b,
    input logic       sb
  );
    logic signed [8:0]  ea;
    logic signed [8:0]  eb;
    logic signed [17:0] pr;
    ea = {sa & a[7], a}; // 9 bits covers both signed and unsigned bytes
    eb = {sb & b[7], b};
    pr = ea * eb;
    return pr[15:0]; // any 8x8 product fits in 16 bits
  endfunction

  //////////////////////////////
  // 4x4 tile per 32-bit lane
  //////////////////////////////
  always_comb begin
    for (int z = 0; z < LANES; z++) begin
      for (int y = 0; y < 4; y++) begin // src1 byte
        for (int x = 0; x < 4; x++) begin // src2 byte
          prod_d[(z*16 + y*4 + x)*16 +: 16] = mul8(src2[(z*4 + x)*8 +: 8],
                                                   src2_sign[z*4 + x],
                                                   src1[(z*4 + y)*8 +: 8],
                                                   src1_sign[z*4 + y]);
        end
      end
    end
  end

  //////////////////////////////
  // stage register
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
    end else begin
      valid_q <= valid;
      ctrl_q  <= ctrl;
    end
  end

  always_ff @(posedge clk) begin
    prod <= prod_d; // captured with valid, back to back uops are fine
  end

endmodule

//--- rtl/vmul_operand_decode.sv
// operand decode in front of the multiplier array, purely combinational
// in_valid low or an unknown funct3 drives zero operands and clears all signs
// vector-scalar forms take the low SEW bits of rs1 for every element
`timescale 1ns/1ps
`include "vmul_params.svh"

module vmul_operand_decode
  import vmul_pkg::*;
(
  input  logic                   in_valid,
  input  mul_uop_t               in_uop,
  output logic [`VMUL_VLEN-1:0]  src2,
  output logic [`VMUL_VLEN-1:0]  src1,
  output logic [`VMUL_VLENB-1:0] src2_sign,
  output logic [`VMUL_VLENB-1:0] src1_sign,
  output mul_ctrl_t              ctrl
);

  logic                   op_ok;
  logic                   is_vv;
  logic                   s2_signed;
  logic                   s1_signed;
  logic                   keep_low;
  logic                   is_vsmul;
  logic [`VMUL_VLEN-1:0]  scalar_bcast;
  logic [`VMUL_VLENB-1:0] s2_mask;
  logic [`VMUL_VLENB-1:0] s1_mask;

  //////////////////////////////
  // op class
  //////////////////////////////
  always_comb begin
    op_ok     = in_valid;
    is_vv     = 1'b1;
    s2_signed = 1'b1;
    s1_signed = 1'b1;
    keep_low  = 1'b0;
    is_vsmul  = 1'b0;
    case (in_uop.funct3)
      OPMVV, OPMVX: begin
        is_vv = (in_uop.funct3 == OPMVV);
        case (in_uop.funct6)
          VMULH:   keep_low = 1'b0; // signed x signed, high half
          VMULHU: begin
            s2_signed = 1'b0;
            s1_signed = 1'b0;
          end
          VMULHSU: s1_signed = 1'b0; // vs2 signed, vs1 unsigned
          default: keep_low = 1'b1; // vmul and unknown codes
        endcase
      end
      OPIVV, OPIVX: begin
        is_vv    = (in_uop.funct3 == OPIVV);
        is_vsmul = 1'b1; // any funct6 here runs as vsmul
      end
      default: op_ok = 1'b0;
    endcase
  end

  //////////////////////////////
  // per-width sign and scalar
  //////////////////////////////
  always_comb begin
    case (in_uop.vs2_eew)
      EEW16: begin
        scalar_bcast = {(`VMUL_VLEN/16){in_uop.rs1_data[15:0]}};
        s2_mask      = {(`VMUL_VLENB/2){s2_signed, 1'b0}}; // sign on high byte only
        s1_mask      = {(`VMUL_VLENB/2){s1_signed, 1'b0}};
      end
      EEW32: begin
        scalar_bcast = {(`VMUL_VLEN/32){in_uop.rs1_data[31:0]}};
        s2_mask      = {(`VMUL_VLENB/4){s2_signed, 3'b000}};
        s1_mask      = {(`VMUL_VLENB/4){s1_signed, 3'b000}};
      end
      default: begin // eew8 and unknown widths
        scalar_bcast = {(`VMUL_VLEN/8){in_uop.rs1_data[7:0]}};
        s2_mask      = {`VMUL_VLENB{s2_signed}};
        s1_mask      = {`VMUL_VLENB{s1_signed}};
      end
    endcase
  end

  assign src2      = op_ok ? in_uop.vs2_data : '0;
  assign src1      = !op_ok ? '0 : (is_vv ? in_uop.vs1_data : scalar_bcast);
  assign src2_sign = op_ok ? s2_mask : '0;
  assign src1_sign = op_ok ? s1_mask : '0;

  always_comb begin
    ctrl.src2_signed = s2_signed & op_ok; // matches the byte masks
    ctrl.src1_signed = s1_signed & op_ok;
    ctrl.keep_low    = keep_low;
    ctrl.is_vsmul    = is_vsmul & op_ok;
    ctrl.vxrm        = in_uop.vxrm;
    ctrl.eew         = in_uop.vs2_eew;
    ctrl.rob_entry   = in_uop.rob_entry;
  end

endmodule

//--- rtl/vmul_pkg.sv
// types shared by the vector multiply unit
// funct3/funct6 values follow the RVV encoding, eew codes are local
`include "vmul_params.svh"

package vmul_pkg;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVX = 3'b100,
    OPMVX = 3'b110
  } funct3_e;

  typedef enum logic [5:0] {
    VMULHU  = 6'b100100,
    VMUL    = 6'b100101,
    VMULHSU = 6'b100110,
    VMULH   = 6'b100111
  } funct6_e;

  // vsmul shares its code with vmulh, funct3 tells them apart
  localparam funct6_e VSMUL = VMULH;

  typedef enum logic [2:0] {
    EEW8  = 3'b000,
    EEW16 = 3'b001,
    EEW32 = 3'b010
  } eew_e;

  typedef enum logic [1:0] {
    RNU = 2'd0, // round to nearest up
    RNE = 2'd1, // round to nearest even
    RDN = 2'd2, // truncate
    ROD = 2'd3  // round to odd
  } vxrm_e;

  typedef struct packed {
    logic [`VMUL_ROB_W-1:0] rob_entry;
    funct6_e                funct6;
    funct3_e                funct3;
    vxrm_e                  vxrm;
    eew_e                   vs2_eew;
    logic [`VMUL_VLEN-1:0]  vs1_data;
    logic [`VMUL_VLEN-1:0]  vs2_data;
    logic [`VMUL_XLEN-1:0]  rs1_data;
  } mul_uop_t;

  typedef struct packed {
    logic                   src2_signed;
    logic                   src1_signed;
    logic                   keep_low; // vmul low half, else high half
    logic                   is_vsmul;
    vxrm_e                  vxrm;
    eew_e                   eew;
    logic [`VMUL_ROB_W-1:0] rob_entry;
  } mul_ctrl_t;

  typedef struct packed {
    logic [`VMUL_ROB_W-1:0] rob_entry;
    logic [`VMUL_VLEN-1:0]  w_data;
    logic [`VMUL_VLENB-1:0] vsaturate; // set on the top byte of a saturated element
  } mul_result_t;

endpackage

//--- rtl/vmul_params.svh
// sizing macros for the vector multiply unit
// VMUL_VLEN must be a multiple of 32, one 4x4 multiplier tile per 32-bit lane
// VMUL_XLEN must be at least 32 so a scalar can feed an EEW32 element
`ifndef VMUL_PARAMS_SVH
`define VMUL_PARAMS_SVH

// vector register width in bits
`define VMUL_VLEN 128

// scalar operand width
`define VMUL_XLEN 32

// bytes per vector register
`define VMUL_VLENB (`VMUL_VLEN / 8)

// reorder buffer index width
`define VMUL_ROB_W 4

// 8x8 products in the array, 16 per 32-bit lane
`define VMUL_PROD_N (`VMUL_VLENB * 4)

`endif
